// File: rv_exec_params.svh
/*
 * rv exec slice parameters
 * widths and depths shared by the design and its testbench
 */
`ifndef RV_EXEC_PARAMS_SVH
`define RV_EXEC_PARAMS_SVH

// datapath
`define RV_XLEN        32  // data and pc width
`define RV_REG_AW      5   // register address width

// flow control
`define RV_IQ_DEPTH    4   // issue queue slots, also the initial input credits
`define RV_RET_CREDITS 2   // initial credits on the retire port
`define RV_CREDIT_W    3   // wide enough for 0..RV_IQ_DEPTH

`endif

// File: rv_isa_pkg.sv
/*
 * rv32i instruction set encodings used by the decoder and execute
 */
`default_nettype none

package rv_isa_pkg;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	// alu operation is funct3 as encoded
	typedef enum logic [2:0] {
		ALU_ADD  = 3'b000,  // add or sub
		ALU_SLL  = 3'b001,
		ALU_SLT  = 3'b010,
		ALU_SLTU = 3'b011,
		ALU_XOR  = 3'b100,
		ALU_SR   = 3'b101,  // srl or sra
		ALU_OR   = 3'b110,
		ALU_AND  = 3'b111
	} alu_op_e;

	// low three bits match the branch funct3
	typedef enum logic [3:0] {
		BR_BEQ  = 4'b0000,
		BR_BNE  = 4'b0001,
		BR_BLT  = 4'b0100,
		BR_BGE  = 4'b0101,
		BR_BLTU = 4'b0110,
		BR_BGEU = 4'b0111,
		BR_NONE = 4'b1000,
		BR_JUMP = 4'b1001   // jal and jalr
	} br_cond_e;

	localparam logic [6:0] F7_BASE = 7'h00;
	localparam logic [6:0] F7_ALT  = 7'h20;  // sub, sra, srai

endpackage

`default_nettype wire

// File: rv_pipe_pkg.sv
/*
 * pipeline records, the decoded operation and the retire record
 */
`default_nettype none

`include "rv_exec_params.svh"

package rv_pipe_pkg;
	import rv_isa_pkg::*;

	typedef struct packed {
		alu_op_e                alu_op;
		logic                   sub;       // add becomes sub
		logic                   sra;       // right shift is arithmetic
		logic [`RV_XLEN-1:0]    op_a;
		logic [`RV_XLEN-1:0]    op_b;
		logic [`RV_XLEN-1:0]    cmp_a;
		logic [`RV_XLEN-1:0]    cmp_b;
		logic [`RV_XLEN-1:0]    tgt_base;
		logic [`RV_XLEN-1:0]    tgt_off;
		br_cond_e               br_cond;
		logic [`RV_REG_AW-1:0]  rd;
		logic                   wr_en;
		logic [`RV_XLEN-1:0]    pc;
	} dec_op_t;

	typedef struct packed {
		logic [`RV_REG_AW-1:0]  rd;
		logic                   wr_en;
		logic [`RV_XLEN-1:0]    result;
		logic [`RV_XLEN-1:0]    next_pc;
		logic                   taken;
	} retire_t;

endpackage

`default_nettype wire

// File: dec_exe_if.sv
/*
 * decode to execute link
 * decoded op forward, stall and register bypass back
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_params.svh"

interface dec_exe_if import rv_pipe_pkg::*; ();

	logic                   valid;
	dec_op_t                op;
	logic                   stall;      // execute holds its register
	logic [`RV_REG_AW-1:0]  byp_rd;
	logic                   byp_wr_en;  // already qualified by execute valid
	logic [`RV_XLEN-1:0]    byp_value;

	modport source (
		output valid, op,
		input  stall, byp_rd, byp_wr_en, byp_value
	);

	modport sink (
		input  valid, op,
		output stall, byp_rd, byp_wr_en, byp_value
	);

endinterface

`default_nettype wire

// File: issue_queue.sv
/*
 * issue queue, a small circular fifo of instruction and pc
 * every pop hands one credit back to the fetch side
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_params.svh"

module issue_queue (
	input  logic                clk,
	input  logic                reset,
	input  logic                push,
	input  logic [31:0]         push_instr,
	input  logic [`RV_XLEN-1:0] push_pc,
	input  logic                pop,
	output logic                head_valid,
	output logic [31:0]         head_instr,
	output logic [`RV_XLEN-1:0] head_pc,
	output logic                credit
);

	localparam int PTR_W = $clog2(`RV_IQ_DEPTH);

	logic [31:0]             instr_mem [`RV_IQ_DEPTH];
	logic [`RV_XLEN-1:0]     pc_mem [`RV_IQ_DEPTH];
	logic [PTR_W-1:0]        wr_ptr, rd_ptr;
	logic [`RV_CREDIT_W-1:0] count;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(`RV_IQ_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (push) begin
			instr_mem[wr_ptr] <= push_instr;
			pc_mem[wr_ptr]    <= push_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (push) wr_ptr <= next_ptr(wr_ptr);
			if (pop) rd_ptr <= next_ptr(rd_ptr);
			count  <= count + `RV_CREDIT_W'(push) - `RV_CREDIT_W'(pop);
			credit <= pop;  // one credit back per freed slot
		end
	end

	assign head_valid = (count != '0);
	assign head_instr = instr_mem[rd_ptr];
	assign head_pc    = pc_mem[rd_ptr];

	// sender must hold a credit for every push
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		push |-> (count < `RV_CREDIT_W'(`RV_IQ_DEPTH)));

endmodule

`default_nettype wire

// File: decoder.sv
/*
 * rv32i decoder, purely combinational
 * picks alu and compare operands, branch target terms, with execute bypass
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_params.svh"

module decoder import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic [31:0]           instr,
	input  logic [`RV_XLEN-1:0]   pc,
	input  logic                  valid,
	output logic [`RV_REG_AW-1:0] rs1_addr,
	output logic [`RV_REG_AW-1:0] rs2_addr,
	input  logic [`RV_XLEN-1:0]   rs1_data,
	input  logic [`RV_XLEN-1:0]   rs2_data,
	dec_exe_if.source             dx
);

	opcode_e               opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [`RV_REG_AW-1:0] rd_f;
	logic [`RV_XLEN-1:0]   imm_i, imm_u, imm_j, imm_b;
	logic [`RV_XLEN-1:0]   src1, src2;
	logic                  r_ok, i_ok, b_ok;
	logic                  wr;
	dec_op_t               op;

	// ####################################################################
	// fields and immediates

	assign opcode   = opcode_e'(instr[6:0]);
	assign rd_f     = instr[11:7];
	assign funct3   = instr[14:12];
	assign rs1_addr = instr[19:15];
	assign rs2_addr = instr[24:20];
	assign funct7   = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

	// alt funct7 only legal on add/sub and the right shifts
	assign r_ok = (funct7 == F7_BASE) ||
		((funct7 == F7_ALT) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
	assign i_ok = (funct3 == 3'b001) ? (funct7 == F7_BASE) :
		(funct3 == 3'b101) ? ((funct7 == F7_BASE) || (funct7 == F7_ALT)) : 1'b1;
	assign b_ok = (funct3 != 3'b010) && (funct3 != 3'b011);

	// ####################################################################
	// bypass from the op sitting in execute

	assign src1 = (dx.byp_wr_en && (dx.byp_rd != '0) && (dx.byp_rd == rs1_addr)) ?
		dx.byp_value : rs1_data;
	assign src2 = (dx.byp_wr_en && (dx.byp_rd != '0) && (dx.byp_rd == rs2_addr)) ?
		dx.byp_value : rs2_data;

	// ####################################################################
	// operand selection

	always_comb begin
		op          = '0;
		op.alu_op   = ALU_ADD;
		op.br_cond  = BR_NONE;
		op.cmp_a    = src1;
		op.cmp_b    = src2;
		op.tgt_base = pc;
		op.pc       = pc;
		wr          = 1'b0;

		case (opcode)
			OPC_OP: begin
				if (r_ok) begin
					wr        = 1'b1;
					op.alu_op = alu_op_e'(funct3);
					op.sub    = (funct3 == 3'b000) && funct7[5];
					op.sra    = funct7[5];
					op.op_a   = src1;
					op.op_b   = src2;
				end
			end
			OPC_OP_IMM: begin
				if (i_ok) begin
					wr        = 1'b1;
					op.alu_op = alu_op_e'(funct3);
					op.sra    = (funct3 == 3'b101) && funct7[5];
					op.op_a   = src1;
					op.op_b   = imm_i;
				end
			end
			OPC_LUI: begin
				wr      = 1'b1;
				op.op_a = imm_u;
			end
			OPC_AUIPC: begin
				wr      = 1'b1;
				op.op_a = pc;
				op.op_b = imm_u;
			end
			OPC_JAL: begin
				wr         = 1'b1;
				op.op_a    = pc;  // link value pc + 4
				op.op_b    = `RV_XLEN'(4);
				op.br_cond = BR_JUMP;
				op.tgt_off = imm_j;
			end
			OPC_JALR: begin
				if (funct3 == 3'b000) begin
					wr          = 1'b1;
					op.op_a     = pc;
					op.op_b     = `RV_XLEN'(4);
					op.br_cond  = BR_JUMP;
					op.tgt_base = src1;
					op.tgt_off  = imm_i;
				end
			end
			OPC_BRANCH: begin
				if (b_ok) begin
					op.br_cond = br_cond_e'({1'b0, funct3});
					op.tgt_off = imm_b;
				end
			end
			default: ;  // unknown opcode retires as a no-op
		endcase

		op.rd    = wr ? rd_f : '0;
		op.wr_en = wr && (rd_f != '0);  // x0 never written
	end

	assign dx.valid = valid;
	assign dx.op    = op;

endmodule

`default_nettype wire

// File: reg_file.sv
/*
 * 32 x 32 register file, two async reads, one sync write, x0 tied to zero
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_params.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`RV_REG_AW-1:0] ra1,
	input  logic [`RV_REG_AW-1:0] ra2,
	output logic [`RV_XLEN-1:0]   rd1,
	output logic [`RV_XLEN-1:0]   rd2,
	input  logic                  we,
	input  logic [`RV_REG_AW-1:0] wa,
	input  logic [`RV_XLEN-1:0]   wd
);

	localparam int NREG = 1 << `RV_REG_AW;

	logic [`RV_XLEN-1:0] regs [NREG];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// x0 reads zero whatever the array holds
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: execute_unit.sv
/*
 * execute stage with op register, alu, branch resolve and retire record
 * retire port is credit controlled
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_params.svh"

module execute_unit import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	dec_exe_if.sink               dx,
	output logic                  pop,
	output logic                  we,
	output logic [`RV_REG_AW-1:0] wa,
	output logic [`RV_XLEN-1:0]   wd,
	output retire_t               ret,
	output logic                  ret_valid,
	input  logic                  ret_credit
);

	logic                    ex_valid;
	dec_op_t                 ex_op;
	logic [`RV_CREDIT_W-1:0] cred_cnt;
	logic                    fire, stall, taken;
	logic [4:0]              shamt;
	logic [`RV_XLEN-1:0]     alu_res, tgt_sum, next_pc;

	assign fire  = ex_valid && (cred_cnt != '0);
	assign stall = ex_valid && (cred_cnt == '0);
	assign pop   = dx.valid && !stall;

	assign dx.stall     = stall;
	assign dx.byp_rd    = ex_op.rd;
	assign dx.byp_wr_en = ex_valid && ex_op.wr_en;
	assign dx.byp_value = alu_res;

	always_ff @(posedge clk) begin
		if (reset) ex_valid <= 1'b0;
		else if (!stall) ex_valid <= dx.valid;
	end

	always_ff @(posedge clk) begin
		if (pop) ex_op <= dx.op;
	end

	// ####################################################################
	// alu and branch

	assign shamt = ex_op.op_b[4:0];

	always_comb begin
		case (ex_op.alu_op)
			ALU_ADD:  alu_res = ex_op.sub ? ex_op.op_a - ex_op.op_b : ex_op.op_a + ex_op.op_b;
			ALU_SLL:  alu_res = ex_op.op_a << shamt;
			ALU_SLT:  alu_res = `RV_XLEN'($signed(ex_op.op_a) < $signed(ex_op.op_b));
			ALU_SLTU: alu_res = `RV_XLEN'(ex_op.op_a < ex_op.op_b);
			ALU_XOR:  alu_res = ex_op.op_a ^ ex_op.op_b;
			ALU_SR:   alu_res = ex_op.sra ? `RV_XLEN'($signed(ex_op.op_a) >>> shamt) :
				ex_op.op_a >> shamt;
			ALU_OR:   alu_res = ex_op.op_a | ex_op.op_b;
			default:  alu_res = ex_op.op_a & ex_op.op_b;
		endcase
	end

	always_comb begin
		case (ex_op.br_cond)
			BR_BEQ:  taken = (ex_op.cmp_a == ex_op.cmp_b);
			BR_BNE:  taken = (ex_op.cmp_a != ex_op.cmp_b);
			BR_BLT:  taken = ($signed(ex_op.cmp_a) < $signed(ex_op.cmp_b));
			BR_BGE:  taken = ($signed(ex_op.cmp_a) >= $signed(ex_op.cmp_b));
			BR_BLTU: taken = (ex_op.cmp_a < ex_op.cmp_b);
			BR_BGEU: taken = (ex_op.cmp_a >= ex_op.cmp_b);
			BR_JUMP: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign tgt_sum = ex_op.tgt_base + ex_op.tgt_off;
	// bit 0 clear is the jalr rule and changes nothing for aligned pc targets
	assign next_pc = taken ? {tgt_sum[`RV_XLEN-1:1], 1'b0} : ex_op.pc + `RV_XLEN'(4);

	// ####################################################################
	// writeback, retire and credits

	assign we = fire && ex_op.wr_en;
	assign wa = ex_op.rd;
	assign wd = alu_res;

	always_ff @(posedge clk) begin
		if (fire) ret <= '{rd: ex_op.rd, wr_en: ex_op.wr_en, result: alu_res,
			next_pc: next_pc, taken: taken};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ret_valid <= 1'b0;
			cred_cnt  <= `RV_CREDIT_W'(`RV_RET_CREDITS);
		end else begin
			ret_valid <= fire;
			case ({fire, ret_credit})
				2'b10:   cred_cnt <= cred_cnt - 1'b1;
				2'b01:   cred_cnt <= cred_cnt + 1'b1;
				default: ;  // spend and return cancel
			endcase
		end
	end

	a_cred_max: assert property (@(posedge clk) disable iff (reset)
		cred_cnt <= `RV_CREDIT_W'(`RV_RET_CREDITS));

endmodule

`default_nettype wire

// File: rv_exec_top.sv
/*
 * rv32i issue, decode, execute slice
 * credit controlled instruction input and retire output
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_params.svh"

module rv_exec_top import rv_pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	input  logic [31:0]           in_instr,
	input  logic [`RV_XLEN-1:0]   in_pc,
	input  logic                  ret_credit,
	output logic                  in_credit,
	output logic                  ret_valid,
	output logic [`RV_REG_AW-1:0] ret_rd,
	output logic                  ret_wr_en,
	output logic [`RV_XLEN-1:0]   ret_result,
	output logic [`RV_XLEN-1:0]   ret_next_pc,
	output logic                  ret_taken
);

	logic                  head_valid, pop, we;
	logic [31:0]           head_instr;
	logic [`RV_XLEN-1:0]   head_pc, rs1_data, rs2_data, wd;
	logic [`RV_REG_AW-1:0] rs1_addr, rs2_addr, wa;
	retire_t               ret;

	dec_exe_if dx ();

	issue_queue u_iq (
		.clk(clk), .reset(reset),
		.push(in_valid), .push_instr(in_instr), .push_pc(in_pc),
		.pop(pop),
		.head_valid(head_valid), .head_instr(head_instr), .head_pc(head_pc),
		.credit(in_credit)
	);

	decoder u_dec (
		.instr(head_instr), .pc(head_pc), .valid(head_valid),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.dx(dx)
	);

	reg_file u_rf (
		.clk(clk), .reset(reset),
		.ra1(rs1_addr), .ra2(rs2_addr), .rd1(rs1_data), .rd2(rs2_data),
		.we(we), .wa(wa), .wd(wd)
	);

	execute_unit u_ex (
		.clk(clk), .reset(reset), .dx(dx), .pop(pop),
		.we(we), .wa(wa), .wd(wd),
		.ret(ret), .ret_valid(ret_valid), .ret_credit(ret_credit)
	);

	// retire record out on plain ports
	assign ret_rd      = ret.rd;
	assign ret_wr_en   = ret.wr_en;
	assign ret_result  = ret.result;
	assign ret_next_pc = ret.next_pc;
	assign ret_taken   = ret.taken;

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
/*
 * testbench clock and reset source, reset held high for a fixed cycle count
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;  // released with the other inputs
	end

endmodule

`default_nettype wire

// File: rv_exec_tb.sv
/*
 * testbench for the rv32i issue, decode, execute slice
 * random programs checked in order against an isa model, credit agents on both ports
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_params.svh"

module rv_exec_tb import rv_pipe_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int N_ALU      = 160;
	localparam int N_UJ       = 64;
	localparam int N_BR       = 72;
	localparam int N_ODD      = 48;
	localparam int N_CRED     = 32;
	localparam int N_TOTAL    = N_ALU + N_UJ + N_BR + N_ODD + N_CRED;

	localparam logic [6:0] OPC_REG   = 7'h33;
	localparam logic [6:0] OPC_IMM   = 7'h13;
	localparam logic [6:0] OPC_LUI   = 7'h37;
	localparam logic [6:0] OPC_AUIPC = 7'h17;
	localparam logic [6:0] OPC_JAL   = 7'h6f;
	localparam logic [6:0] OPC_JALR  = 7'h67;
	localparam logic [6:0] OPC_BR    = 7'h63;

	logic        clk, reset;
	logic        in_valid, in_credit, ret_credit, ret_valid, ret_wr_en, ret_taken;
	logic [31:0] in_instr, in_pc, ret_result, ret_next_pc;
	logic [4:0]  ret_rd;

	logic [31:0] lfsr = 32'd92199;
	logic [31:0] mregs [32];        // isa model register file
	logic [31:0] send_instr_q [$];
	logic [31:0] send_pc_q [$];
	retire_t     exp_q [$];
	int          errors = 0;
	int          checks = 0;
	int          retired = 0;
	int          in_cred, ret_avail, owed, gap;
	int          ret_hold = 0;      // cycles the downstream side withholds credits

	tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) u_clk (.clk(clk), .reset(reset));

	rv_exec_top UUT (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_instr(in_instr), .in_pc(in_pc),
		.ret_credit(ret_credit), .in_credit(in_credit),
		.ret_valid(ret_valid), .ret_rd(ret_rd), .ret_wr_en(ret_wr_en),
		.ret_result(ret_result), .ret_next_pc(ret_next_pc), .ret_taken(ret_taken)
	);

	// ####################################################################
	// random source, check and report helpers

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	// ####################################################################
	// isa model

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    return (a < b) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic retire_t model_exec(input logic [31:0] ins, input logic [31:0] pc);
		retire_t     r;
		logic [6:0]  f7;
		logic [2:0]  f3;
		logic [31:0] a, b, imm_i, imm_u, imm_j, imm_b, res, tgt;
		logic        ok, wr, tk;
		f7    = ins[31:25];
		f3    = ins[14:12];
		a     = mregs[ins[19:15]];
		b     = mregs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_u = {ins[31:12], 12'h000};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		ok    = 1'b1;
		wr    = 1'b1;
		tk    = 1'b0;
		res   = '0;
		tgt   = '0;
		case (ins[6:0])
			OPC_REG: begin
				ok  = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
				res = alu_ref(f3, f7[5], a, b);
			end
			OPC_IMM: begin
				if (f3 == 3'd1) ok = (f7 == 7'h00);
				if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
				res = alu_ref(f3, (f3 == 3'd5) && f7[5], a, imm_i);
			end
			OPC_LUI:   res = imm_u;
			OPC_AUIPC: res = pc + imm_u;
			OPC_JAL: begin
				res = pc + 32'd4;
				tk  = 1'b1;
				tgt = pc + imm_j;
			end
			OPC_JALR: begin
				ok  = (f3 == 3'd0);
				res = pc + 32'd4;
				tk  = 1'b1;
				tgt = (a + imm_i) & ~32'd1;
			end
			OPC_BR: begin
				ok  = (f3 != 3'd2) && (f3 != 3'd3);
				wr  = 1'b0;
				tk  = branch_ref(f3, a, b);
				tgt = pc + imm_b;
			end
			default: ok = 1'b0;  // no load, store or system in this slice
		endcase
		r.rd      = ins[11:7];
		r.wr_en   = ok && wr && (ins[11:7] != 5'd0);
		r.result  = res;
		r.taken   = ok && tk;
		r.next_pc = r.taken ? tgt : pc + 32'd4;
		if (r.wr_en) mregs[ins[11:7]] = res;
		return r;
	endfunction

	// ####################################################################
	// instruction generators

	// small register set so back to back dependencies are common
	function automatic logic [31:0] gen_alu(input logic [4:0] rd);
		logic [2:0]  f3;
		logic [4:0]  rs1, rs2;
		logic [11:0] imm;
		logic        alt, reg_form;
		f3       = 3'(take_bits(3));
		rs1      = 5'(take_bits(3));
		rs2      = 5'(take_bits(3));
		imm      = 12'(take_bits(12));
		alt      = 1'(take_bits(1));
		reg_form = 1'(take_bits(1));
		if ((f3 != 3'd0) && (f3 != 3'd5)) alt = 1'b0;
		if (reg_form) return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, OPC_REG};
		if (f3 == 3'd1) imm[11:5] = 7'h00;
		if (f3 == 3'd5) imm[11:5] = {1'b0, alt, 5'b00000};
		return {imm, rs1, f3, rd, OPC_IMM};
	endfunction

	function automatic logic [31:0] gen_upper_jump();
		logic [4:0]  rd, rs1;
		logic [1:0]  kind;
		logic [19:0] hi;
		rd   = 5'(take_bits(5));
		rs1  = 5'(take_bits(3));
		kind = 2'(take_bits(2));
		hi   = 20'(take_bits(20));
		case (kind)
			2'd0:    return {hi, rd, OPC_LUI};
			2'd1:    return {hi, rd, OPC_AUIPC};
			2'd2:    return {hi, rd, OPC_JAL};  // any 20 bits form a jal offset
			default: return {hi[11:0], rs1, 3'b000, rd, OPC_JALR};
		endcase
	endfunction

	function automatic logic [31:0] gen_branch(input logic [2:0] f3);
		logic [4:0] rs1, rs2, lo;
		logic [6:0] hi;
		rs1 = 5'(take_bits(3));
		rs2 = 5'(take_bits(3));
		hi  = 7'(take_bits(7));
		lo  = 5'(take_bits(5));
		return {hi, rs2, rs1, f3, lo, OPC_BR};
	endfunction

	// illegal encodings, writes to x0 and reads of x0
	function automatic logic [31:0] gen_odd(input logic [2:0] kind);
		logic [31:0] w;
		logic [4:0]  rd;
		w  = take_bits(32);
		rd = 5'(take_bits(3));
		case (kind)
			3'd0:    return w;
			3'd1:    return {w[31:26], 1'b1, w[24:7], OPC_REG};
			3'd2:    return {w[31:26], 1'b1, w[24:15], 3'b001, w[11:7], OPC_IMM};
			3'd3:    return {w[31:13], 1'b1, w[11:7], OPC_JALR};
			3'd4:    return {w[31:15], 2'b01, w[12], w[11:7], OPC_BR};
			3'd5:    return gen_alu(5'd0);
			3'd6:    return {w[31:20], 5'd0, 3'b000, rd, OPC_IMM};
			default: return {7'h00, 10'd0, w[14:12], rd, OPC_REG};
		endcase
	endfunction

	function automatic logic [31:0] pick_instr(input int num, input int idx);
		logic [2:0] bf;
		case (num)
			1, 5: return gen_alu(5'(take_bits(3)));
			2: return (take_bits(2) == 0) ? gen_alu(5'(take_bits(3))) : gen_upper_jump();
			3: begin
				if (idx % 3 == 2) return gen_alu(5'(take_bits(3)));
				bf = 3'((idx - idx / 3) % 6);
				if (bf >= 3'd2) bf = bf + 3'd2;  // skip the unused funct3 codes
				return gen_branch(bf);
			end
			default: return gen_odd(3'(take_bits(3)));
		endcase
	endfunction

	// ####################################################################
	// agents and monitor

	// sender, one instruction per credit
	always @(posedge clk) begin
		#1;
		if (reset) begin
			in_valid = 1'b0;
			in_cred  = `RV_IQ_DEPTH;
		end else begin
			if (in_credit) in_cred++;
			if (in_cred > `RV_IQ_DEPTH) report_error("input credits exceed the issue queue depth");
			if ((in_cred != 0) && (send_instr_q.size() != 0)) begin
				in_instr = send_instr_q.pop_front();
				in_pc    = send_pc_q.pop_front();
				in_valid = 1'b1;
				in_cred--;
			end else begin
				in_valid = 1'b0;
			end
		end
	end

	// downstream side, hands each retire credit back after a random gap
	always @(posedge clk) begin
		#1;
		if (reset) begin
			ret_credit = 1'b0;
			ret_avail  = `RV_RET_CREDITS;
			owed       = 0;
			gap        = 0;
		end else begin
			if (ret_valid) begin
				if (ret_avail == 0) report_error("ret_valid fired with no retire credit");
				else ret_avail--;
				owed++;
			end
			if (ret_credit) ret_avail++;  // pulse seen by the DUT at this edge
			if (ret_hold != 0) begin
				ret_hold--;
				ret_credit = 1'b0;
			end else if ((owed != 0) && (gap == 0)) begin
				ret_credit = 1'b1;
				owed--;
				gap = take_bits(2);
			end else begin
				ret_credit = 1'b0;
				if (gap != 0) gap--;
			end
		end
	end

	always @(negedge clk) begin
		retire_t e;
		if (!reset && ret_valid) begin
			if (exp_q.size() == 0) begin
				report_error("ret_valid with no instruction outstanding");
			end else begin
				e = exp_q.pop_front();
				retired++;
				check("ret_wr_en", 32'(ret_wr_en), 32'(e.wr_en));
				if (e.wr_en) begin
					check("ret_rd", 32'(ret_rd), 32'(e.rd));
					check("ret_result", ret_result, e.result);
				end
				check("ret_taken", 32'(ret_taken), 32'(e.taken));
				check("ret_next_pc", ret_next_pc, e.next_pc);
			end
		end
	end

	// ####################################################################
	// tests

	task automatic run_test(input int num, input string name, input int n);
		int          err0, ret0;
		logic [31:0] ins, pc;
		err0 = errors;
		ret0 = retired;
		@(negedge clk);
		if (num == 5) ret_hold = 60;
		for (int i = 0; i < n; i++) begin
			ins = pick_instr(num, i);
			pc  = {30'(take_bits(30)), 2'b00};
			exp_q.push_back(model_exec(ins, pc));
			send_instr_q.push_back(ins);
			send_pc_q.push_back(pc);
		end
		while (exp_q.size() != 0) @(negedge clk);
		if (in_cred != `RV_IQ_DEPTH) report_error("input credits not all returned");
		$display("test %0d %s: %0d of %0d retired, %0d errors",
			num, name, retired - ret0, n, errors - err0);
	endtask

	initial begin
		in_valid   = 1'b0;
		in_instr   = '0;
		in_pc      = '0;
		ret_credit = 1'b0;
		for (int i = 0; i < 32; i++) mregs[i] = '0;
		wait (!reset);
		run_test(1, "alu programs", N_ALU);
		run_test(2, "lui auipc jal jalr", N_UJ);
		run_test(3, "branches", N_BR);
		run_test(4, "illegal and x0", N_ODD);
		run_test(5, "credit stall", N_CRED);
		$display("summary: %0d retired, %0d checks, %0d errors", retired, checks, errors);
		if (errors == 0) $display("Testbench passed");
		else $display("Testbench failed");
		$finish;
	end

	// watchdog, 40 cycles per instruction
	initial begin
		#(N_TOTAL * 40 * CLK_PERIOD);
		$display("timeout: instructions still outstanding after %0d cycles", N_TOTAL * 40);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rv_exec_top.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
dec_exe_if.sv
issue_queue.sv
decoder.sv
reg_file.sv
execute_unit.sv
rv_exec_top.sv
tb_clk_gen.sv
rv_exec_tb.sv
